// File: hdl/renameMap_cfg.svh
`ifndef RENAMEMAP_CFG_SVH
`define RENAMEMAP_CFG_SVH

// Lanes renamed per cycle
`define RN_DISPATCH_WIDTH 4

// Logical register file, one table entry per register
`define RN_LOG_REGS 32
`define RN_LOG_ID_BITS 5

// Physical register tag width
`define RN_PHYS_ID_BITS 6

// AMT packets written per repair cycle
`define RN_REPAIR_PACKETS 2

`endif

// File: hdl/renamePkg.sv
`include "renameMap_cfg.svh"

package renamePkg;

  // Register ids
  typedef logic [`RN_LOG_ID_BITS-1:0] logId_t;
  typedef logic [`RN_PHYS_ID_BITS-1:0] physId_t;

  // Logical register as it comes from decode
  typedef struct packed {
    logic   valid;
    logId_t id;
  } logReg_t;

  // Renamed register handed to dispatch
  typedef struct packed {
    logic    valid;
    physId_t id;
  } physReg_t;

endpackage

// File: hdl/rmtInitSeq.sv
`include "renameMap_cfg.svh"

module rmtInitSeq (
  input  logic                clk,
  input  logic                resetRams_i,
  output logic                initWe_o,
  output renamePkg::logId_t   initAddr_o,
  output renamePkg::physId_t  initData_o,
  output logic                ready_o
);

  typedef enum logic [1:0] {SeqStart, SeqRun, SeqDone} seqState_e;

  seqState_e           state;
  seqState_e           nextState;
  renamePkg::logId_t   addrCnt;
  renamePkg::logId_t   nextAddrCnt;
  renamePkg::physId_t  dataCnt;
  renamePkg::physId_t  nextDataCnt;

  always_ff @(posedge clk or posedge resetRams_i)
  begin
    if (resetRams_i)
    begin
      state   <= SeqStart;
      addrCnt <= '0;
      dataCnt <= '0;
    end
    else
    begin
      state   <= nextState;
      addrCnt <= nextAddrCnt;
      dataCnt <= nextDataCnt;
    end
  end

  always_comb
  begin
    nextState   = state;
    nextAddrCnt = addrCnt;
    nextDataCnt = dataCnt;
    case (state)
      SeqStart:
      begin
        nextState   = SeqRun;
        nextAddrCnt = '0;
        nextDataCnt = '0;
      end
      SeqRun:
      begin
        // One entry per cycle, identity value
        nextAddrCnt = addrCnt + 1'b1;
        nextDataCnt = dataCnt + 1'b1;
        if (addrCnt == `RN_LOG_ID_BITS'(`RN_LOG_REGS - 1))
        begin
          nextState = SeqDone;
        end
      end
      default:
      begin
        nextState = SeqDone;
      end
    endcase
  end

  assign initWe_o   = (state == SeqRun);
  assign initAddr_o = addrCnt;
  assign initData_o = dataCnt;
  // Table usable only once every entry holds its identity value
  assign ready_o    = (state == SeqDone);

endmodule

// File: hdl/destAllocator.sv
`include "renameMap_cfg.svh"

module destAllocator (
  input  renamePkg::logReg_t  logDest_i  [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::physId_t  freePhys_i [0:`RN_DISPATCH_WIDTH-1],
  input  logic                stall_i,
  input  logic                recover_i,
  output renamePkg::physId_t  phyDest_o  [0:`RN_DISPATCH_WIDTH-1],
  output logic                writeEn_o  [0:`RN_DISPATCH_WIDTH-1]
);

  logic superseded [0:`RN_DISPATCH_WIDTH-1];

  // Free registers are handed out in lane order, skipping lanes
  // without a destination
  always_comb
  begin
    int slot;
    slot = 0;
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      phyDest_o[i] = '0;
      if (logDest_i[i].valid)
      begin
        phyDest_o[i] = freePhys_i[slot];
        slot = slot + 1;
      end
    end
  end

  // A younger lane writing the same logical register owns the entry
  always_comb
  begin
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      superseded[i] = 1'b0;
      for (int j = i + 1; j < `RN_DISPATCH_WIDTH; j++)
      begin
        if (logDest_i[j].valid && (logDest_i[j].id == logDest_i[i].id))
        begin
          superseded[i] = 1'b1;
        end
      end
    end
  end

  always_comb
  begin
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      // Stalled or flushed bundles must not touch the table
      writeEn_o[i] = logDest_i[i].valid & ~superseded[i] & ~stall_i & ~recover_i;
    end
  end

endmodule

// File: hdl/mapTableRam.sv
`include "renameMap_cfg.svh"

module mapTableRam (
  input  logic                clk,

  // Identity load from the init sequencer
  input  logic                initWe_i,
  input  renamePkg::logId_t   initAddr_i,
  input  renamePkg::physId_t  initData_i,

  // AMT repair packets
  input  logic                repair_i,
  input  renamePkg::logId_t   repairAddr_i [0:`RN_REPAIR_PACKETS-1],
  input  renamePkg::physId_t  repairData_i [0:`RN_REPAIR_PACKETS-1],

  // Rename writes, one per lane
  input  logic                writeEn_i    [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::logReg_t  writeAddr_i  [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::physId_t  writeData_i  [0:`RN_DISPATCH_WIDTH-1],

  // Two source reads per lane
  input  renamePkg::logReg_t  readAddr1_i  [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::logReg_t  readAddr2_i  [0:`RN_DISPATCH_WIDTH-1],
  output renamePkg::physId_t  readData1_o  [0:`RN_DISPATCH_WIDTH-1],
  output renamePkg::physId_t  readData2_o  [0:`RN_DISPATCH_WIDTH-1]
);

  renamePkg::physId_t mapMem [0:`RN_LOG_REGS-1];

  // Write mux, init over repair over rename
  always_ff @(posedge clk)
  begin
    if (initWe_i)
    begin
      mapMem[initAddr_i] <= initData_i;
    end
    else if (repair_i)
    begin
      // Later packet wins on a shared address
      for (int p = 0; p < `RN_REPAIR_PACKETS; p++)
      begin
        mapMem[repairAddr_i[p]] <= repairData_i[p];
      end
    end
    else
    begin
      for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
      begin
        if (writeEn_i[i])
        begin
          mapMem[writeAddr_i[i].id] <= writeData_i[i];
        end
      end
    end
  end

  // Asynchronous reads
  always_comb
  begin
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      readData1_o[i] = mapMem[readAddr1_i[i].id];
      readData2_o[i] = mapMem[readAddr2_i[i].id];
    end
  end

endmodule

// File: hdl/srcBypass.sv
`include "renameMap_cfg.svh"

module srcBypass (
  input  renamePkg::logReg_t   logDest_i   [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::logReg_t   logSrc1_i   [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::logReg_t   logSrc2_i   [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::physId_t   phyDest_i   [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::physId_t   tableSrc1_i [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::physId_t   tableSrc2_i [0:`RN_DISPATCH_WIDTH-1],
  output renamePkg::physReg_t  phySrc1_o   [0:`RN_DISPATCH_WIDTH-1],
  output renamePkg::physReg_t  phySrc2_o   [0:`RN_DISPATCH_WIDTH-1]
);

  // Table mapping, overridden by the youngest older lane writing the source
  function automatic renamePkg::physId_t resolveSrc(
    input int                  lane,
    input renamePkg::logId_t   srcId,
    input renamePkg::physId_t  tableMap
  );
    renamePkg::physId_t result;
    result = tableMap;
    // Oldest first so the youngest match is kept
    for (int j = 0; j < lane; j++)
    begin
      if (logDest_i[j].valid && (logDest_i[j].id == srcId))
      begin
        result = phyDest_i[j];
      end
    end
    return result;
  endfunction

  always_comb
  begin
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      phySrc1_o[i].valid = logSrc1_i[i].valid;
      phySrc1_o[i].id    = resolveSrc(i, logSrc1_i[i].id, tableSrc1_i[i]);
      phySrc2_o[i].valid = logSrc2_i[i].valid;
      phySrc2_o[i].id    = resolveSrc(i, logSrc2_i[i].id, tableSrc2_i[i]);
    end
  end

endmodule

// File: hdl/renameMapTable.sv
`include "renameMap_cfg.svh"

module renameMapTable (
  input  logic                 clk,
  input  logic                 resetRams_i,

  input  logic                 stall_i,
  input  logic                 recover_i,

  // Repair from the AMT
  input  logic                 repair_i,
  input  renamePkg::logId_t    repairAddr_i [0:`RN_REPAIR_PACKETS-1],
  input  renamePkg::physId_t   repairData_i [0:`RN_REPAIR_PACKETS-1],

  // Decoded bundle
  input  renamePkg::logReg_t   logDest_i    [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::logReg_t   logSrc1_i    [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::logReg_t   logSrc2_i    [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::physId_t   freePhys_i   [0:`RN_DISPATCH_WIDTH-1],

  // Renamed bundle
  output renamePkg::physReg_t  phyDest_o    [0:`RN_DISPATCH_WIDTH-1],
  output renamePkg::physReg_t  phySrc1_o    [0:`RN_DISPATCH_WIDTH-1],
  output renamePkg::physReg_t  phySrc2_o    [0:`RN_DISPATCH_WIDTH-1],

  output logic                 ready_o
);

  logic                initWe;
  renamePkg::logId_t   initAddr;
  renamePkg::physId_t  initData;
  renamePkg::physId_t  phyDest   [0:`RN_DISPATCH_WIDTH-1];
  logic                writeEn   [0:`RN_DISPATCH_WIDTH-1];
  renamePkg::physId_t  tableSrc1 [0:`RN_DISPATCH_WIDTH-1];
  renamePkg::physId_t  tableSrc2 [0:`RN_DISPATCH_WIDTH-1];

  rmtInitSeq i_rmtInitSeq (
    .clk         (clk),
    .resetRams_i (resetRams_i),
    .initWe_o    (initWe),
    .initAddr_o  (initAddr),
    .initData_o  (initData),
    .ready_o     (ready_o)
  );

  destAllocator i_destAllocator (
    .logDest_i  (logDest_i),
    .freePhys_i (freePhys_i),
    .stall_i    (stall_i),
    .recover_i  (recover_i),
    .phyDest_o  (phyDest),
    .writeEn_o  (writeEn)
  );

  mapTableRam i_mapTableRam (
    .clk          (clk),
    .initWe_i     (initWe),
    .initAddr_i   (initAddr),
    .initData_i   (initData),
    .repair_i     (repair_i),
    .repairAddr_i (repairAddr_i),
    .repairData_i (repairData_i),
    .writeEn_i    (writeEn),
    .writeAddr_i  (logDest_i),
    .writeData_i  (phyDest),
    .readAddr1_i  (logSrc1_i),
    .readAddr2_i  (logSrc2_i),
    .readData1_o  (tableSrc1),
    .readData2_o  (tableSrc2)
  );

  srcBypass i_srcBypass (
    .logDest_i   (logDest_i),
    .logSrc1_i   (logSrc1_i),
    .logSrc2_i   (logSrc2_i),
    .phyDest_i   (phyDest),
    .tableSrc1_i (tableSrc1),
    .tableSrc2_i (tableSrc2),
    .phySrc1_o   (phySrc1_o),
    .phySrc2_o   (phySrc2_o)
  );

  // Destination valid passes straight through from decode
  for (genvar g = 0; g < `RN_DISPATCH_WIDTH; g++)
  begin : gDestOut
    assign phyDest_o[g] = {logDest_i[g].valid, phyDest[g]};
  end

endmodule

// File: sim/renameMapTable_chk.sv
`include "renameMap_cfg.svh"

module renameMapTable_chk (
  input  logic                clk,
  input  logic                resetRams_i,
  input  logic                ready_i,
  input  logic                initWe_i,
  input  logic                writeEn_i   [0:`RN_DISPATCH_WIDTH-1],
  input  renamePkg::logReg_t  writeAddr_i [0:`RN_DISPATCH_WIDTH-1]
);
  timeunit 1ns;
  timeprecision 1ps;

  logic anyRenameWrite;
  logic addrCollision;
  int   assertFails = 0;

  always_comb
  begin
    anyRenameWrite = 1'b0;
    addrCollision  = 1'b0;
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      if (writeEn_i[i])
      begin
        anyRenameWrite = 1'b1;
      end
      for (int j = i + 1; j < `RN_DISPATCH_WIDTH; j++)
      begin
        if (writeEn_i[i] && writeEn_i[j] && (writeAddr_i[i].id == writeAddr_i[j].id))
        begin
          addrCollision = 1'b1;
        end
      end
    end
  end

  // Table not usable while the RAMs are reset
  readyLowInReset: assert property (@(posedge clk) resetRams_i |-> !ready_i)
    else
    begin
      assertFails++;
      $error("ready_o high while resetRams_i is high");
    end

  // Identity load owns the write port
  noRenameDuringInit: assert property (
    @(posedge clk) disable iff (resetRams_i) initWe_i |-> !anyRenameWrite)
    else
    begin
      assertFails++;
      $error("rename write enable high during table initialization");
    end

  noWriteCollision: assert property (
    @(posedge clk) disable iff (resetRams_i) !addrCollision)
    else
    begin
      assertFails++;
      $error("two rename write enables target the same entry");
    end

endmodule

// File: sim/renameMapTable_tb.sv
`include "renameMap_cfg.svh"

module renameMapTable_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int Lanes      = `RN_DISPATCH_WIDTH;
  localparam int Packets    = `RN_REPAIR_PACKETS;
  localparam int HalfPeriod = 20;

  logic                 clk;
  logic                 resetRams;
  logic                 stall;
  logic                 recover;
  logic                 repair;
  renamePkg::logId_t    repairAddr [0:Packets-1];
  renamePkg::physId_t   repairData [0:Packets-1];
  renamePkg::logReg_t   logDest    [0:Lanes-1];
  renamePkg::logReg_t   logSrc1    [0:Lanes-1];
  renamePkg::logReg_t   logSrc2    [0:Lanes-1];
  renamePkg::physId_t   freePhys   [0:Lanes-1];
  renamePkg::physReg_t  phyDest    [0:Lanes-1];
  renamePkg::physReg_t  phySrc1    [0:Lanes-1];
  renamePkg::physReg_t  phySrc2    [0:Lanes-1];
  logic                 ready;

  // Reference model state
  renamePkg::physId_t   refTable [0:`RN_LOG_REGS-1];
  renamePkg::physId_t   expAlloc [0:Lanes-1];
  string                stimLines [$];
  int                   errorCount = 0;
  int                   checkCount = 0;
  int                   cycleCount = 0;
  int                   cycleLimit = 60;

  renameMapTable i_renameMapTable (
    .clk          (clk),
    .resetRams_i  (resetRams),
    .stall_i      (stall),
    .recover_i    (recover),
    .repair_i     (repair),
    .repairAddr_i (repairAddr),
    .repairData_i (repairData),
    .logDest_i    (logDest),
    .logSrc1_i    (logSrc1),
    .logSrc2_i    (logSrc2),
    .freePhys_i   (freePhys),
    .phyDest_o    (phyDest),
    .phySrc1_o    (phySrc1),
    .phySrc2_o    (phySrc2),
    .ready_o      (ready)
  );

  bind renameMapTable renameMapTable_chk i_renameMapTableChk (
    .clk         (clk),
    .resetRams_i (resetRams_i),
    .ready_i     (ready_o),
    .initWe_i    (initWe),
    .writeEn_i   (writeEn),
    .writeAddr_i (logDest_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("Timeout: run still going after %0d cycles", cycleCount);
      $display("Errors found");
      $finish;
    end
  end

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  task automatic clearInputs();
    stall   = 1'b0;
    recover = 1'b0;
    repair  = 1'b0;
    for (int p = 0; p < Packets; p++)
    begin
      repairAddr[p] = '0;
      repairData[p] = '0;
    end
    for (int i = 0; i < Lanes; i++)
    begin
      logDest[i]  = '0;
      logSrc1[i]  = '0;
      logSrc2[i]  = '0;
      freePhys[i] = '0;
    end
  endtask

  task automatic readStim();
    int    fd;
    string line;
    fd = $fopen("sim/rename_stim.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file sim/rename_stim.txt");
      errorCount++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        // Skip comments and blank lines
        if (line.len() > 1 && line[0] != "#")
        begin
          stimLines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  // Free registers handed out in lane order
  // Lanes without a destination get zero
  task automatic allocateExpected();
    int taken;
    taken = 0;
    for (int i = 0; i < Lanes; i++)
    begin
      expAlloc[i] = '0;
      if (logDest[i].valid)
      begin
        expAlloc[i] = freePhys[taken];
        taken++;
      end
    end
  endtask

  // Nearest older writer wins over the table
  function automatic renamePkg::physId_t sourceMapping(input int lane,
                                                       input renamePkg::logId_t srcId);
    for (int j = lane - 1; j >= 0; j--)
    begin
      if (logDest[j].valid && (logDest[j].id == srcId))
      begin
        return expAlloc[j];
      end
    end
    return refTable[srcId];
  endfunction

  task automatic checkBundle();
    renamePkg::physReg_t expected;
    allocateExpected();
    for (int i = 0; i < Lanes; i++)
    begin
      expected = {logDest[i].valid, expAlloc[i]};
      checkValue($sformatf("phyDest_o[%0d]", i), expected, phyDest[i]);
      expected = {logSrc1[i].valid, sourceMapping(i, logSrc1[i].id)};
      checkValue($sformatf("phySrc1_o[%0d]", i), expected, phySrc1[i]);
      expected = {logSrc2[i].valid, sourceMapping(i, logSrc2[i].id)};
      checkValue($sformatf("phySrc2_o[%0d]", i), expected, phySrc2[i]);
    end
  endtask

  // Lanes applied in order so the youngest writer stays
  task automatic commitBundle();
    if (!stall && !recover)
    begin
      for (int i = 0; i < Lanes; i++)
      begin
        if (logDest[i].valid)
        begin
          refTable[logDest[i].id] = expAlloc[i];
        end
      end
    end
  endtask

  task automatic reportMalformed(input string line);
    errorCount++;
    $display("Malformed stimulus line: %s", line);
  endtask

  // Every entry read back once through both sources of each lane
  task automatic checkIdentity();
    renamePkg::logId_t id;
    for (int b = 0; b < `RN_LOG_REGS / (2 * Lanes); b++)
    begin
      @(negedge clk);
      clearInputs();
      for (int i = 0; i < Lanes; i++)
      begin
        logSrc1[i] = {1'b1, renamePkg::logId_t'(b * 2 * Lanes + 2 * i)};
        logSrc2[i] = {1'b1, renamePkg::logId_t'(b * 2 * Lanes + 2 * i + 1)};
      end
      #(HalfPeriod / 2);
      checkBundle();
      for (int i = 0; i < Lanes; i++)
      begin
        id = logSrc1[i].id;
        checkValue($sformatf("phySrc1_o[%0d] identity", i), id, phySrc1[i].id);
        id = logSrc2[i].id;
        checkValue($sformatf("phySrc2_o[%0d] identity", i), id, phySrc2[i].id);
      end
    end
  endtask

  task automatic runLine(input string line);
    logic [7:0] op;
    logic [7:0] st;
    logic [7:0] rc;
    logic [7:0] fld [0:15];
    int         n;
    n = $sscanf(line, "%c", op);
    @(negedge clk);
    clearInputs();
    if (op == "R")
    begin
      n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  op, st, rc, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                  fld[6], fld[7], fld[8], fld[9], fld[10], fld[11], fld[12],
                  fld[13], fld[14], fld[15]);
      if (n != 19)
      begin
        reportMalformed(line);
      end
      stall   = st[0];
      recover = rc[0];
      for (int i = 0; i < Lanes; i++)
      begin
        logDest[i]  = fld[4 * i][5:0];
        logSrc1[i]  = fld[4 * i + 1][5:0];
        logSrc2[i]  = fld[4 * i + 2][5:0];
        freePhys[i] = fld[4 * i + 3][5:0];
      end
      #(HalfPeriod / 2);
      checkBundle();
      commitBundle();
    end
    else if (op == "P")
    begin
      n = $sscanf(line, "%c %h %h %h %h", op, fld[0], fld[1], fld[2], fld[3]);
      if (n != 5)
      begin
        reportMalformed(line);
      end
      repair = 1'b1;
      for (int p = 0; p < Packets; p++)
      begin
        repairAddr[p] = fld[2 * p][4:0];
        repairData[p] = fld[2 * p + 1][5:0];
        // Higher packet index overwrites
        refTable[repairAddr[p]] = repairData[p];
      end
    end
    else if (op == "E")
    begin
      n = $sscanf(line, "%c %h %h", op, fld[0], fld[1]);
      if (n != 3)
      begin
        reportMalformed(line);
      end
      logSrc1[0] = {1'b1, fld[0][4:0]};
      #(HalfPeriod / 2);
      checkBundle();
      checkValue($sformatf("phySrc1_o[0] for r%0d", fld[0][4:0]), fld[1][5:0], phySrc1[0].id);
    end
    else
    begin
      reportMalformed(line);
    end
  endtask

  initial
  begin
    int waitCycles;
    clearInputs();
    resetRams = 1'b1;
    readStim();
    cycleLimit = 60 + 4 * stimLines.size();
    repeat (5)
    begin
      @(negedge clk);
      checkValue("ready_o", 1'b0, ready);
    end
    resetRams = 1'b0;
    for (int k = 0; k < `RN_LOG_REGS; k++)
    begin
      refTable[k] = renamePkg::physId_t'(k);
    end
    waitCycles = 0;
    while (ready !== 1'b1 && waitCycles < 50)
    begin
      @(negedge clk);
      waitCycles++;
    end
    if (ready !== 1'b1)
    begin
      $display("ready_o never rose after the RAM reset was released");
      errorCount++;
    end
    else
    begin
      checkIdentity();
      foreach (stimLines[n])
      begin
        runLine(stimLines[n]);
      end
      @(negedge clk);
    end
    errorCount = errorCount + i_renameMapTable.i_renameMapTableChk.assertFails;
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: renameMap.f
+incdir+hdl
hdl/renamePkg.sv
hdl/rmtInitSeq.sv
hdl/destAllocator.sv
hdl/mapTableRam.sv
hdl/srcBypass.sv
hdl/renameMapTable.sv
sim/renameMapTable_chk.sv
sim/renameMapTable_tb.sv

// File: Bender.yml
package:
  name: renameMap

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/renamePkg.sv
      - hdl/rmtInitSeq.sv
      - hdl/destAllocator.sv
      - hdl/mapTableRam.sv
      - hdl/srcBypass.sv
      - hdl/renameMapTable.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/renameMapTable_chk.sv
      - sim/renameMapTable_tb.sv

// File: sim/rename_stim.txt
# R stall recover, then lanes 0..3 as: dest src1 src2 freePhys (hex, bit 5 of a register = valid)
# P addr0 data0 addr1 data1 writes repair packets; E logId physId reads lane 0 src1 and expects physId
R 0 0 21 22 24 28 00 21 25 29 21 21 24 2A 24 21 24 2B
E 01 29
E 04 2A
R 1 0 22 21 22 30 00 00 00 31 00 00 00 32 00 00 00 33
E 02 02
E 01 29
R 0 1 23 23 00 34 00 00 00 35 00 00 00 36 00 00 00 37
E 03 03
P 05 3C 06 3D
E 05 3C
E 06 3D
P 07 11 07 12
E 07 12
R 0 0 25 25 26 14 26 25 27 15 25 26 25 16 27 25 26 17
E 05 16
E 06 15
E 07 17
E 1F 1F
E 00 00
